/* Makefile */
TOP = tb_fetch_subsystem

# Build, run, then decide on the log contents
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

obj_dir/V$(TOP): build.f $(wildcard hw/*.sv include/*.svh testbench/*.sv)
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all lint clean

/* build.f */
+incdir+include
hw/proc_defs_pkg.sv
hw/cache_defs_pkg.sv
hw/icache_controller.sv
hw/cache_set.sv
hw/icache.sv
hw/inst_memory.sv
hw/fetch_subsystem.sv
testbench/tb_fetch_subsystem.sv

/* hw/cache_defs_pkg.sv */
`include "icache_settings.svh"

// Field types and state encoding of the instruction cache
package cache_defs_pkg;

    // Tag takes whatever is left above index, offset and byte bits
    typedef logic [`INST_ADDR_WIDTH-`ICACHE_INDEX_WIDTH-`ICACHE_OFFSET_WIDTH-3:0] icache_tag_t;
    typedef logic [`ICACHE_INDEX_WIDTH-1:0]  icache_index_t;   // Line select
    typedef logic [`ICACHE_OFFSET_WIDTH-1:0] icache_offset_t;  // Word within line

    // -------------------------------------------------------------------
    // Address split, MSB first
    // -------------------------------------------------------------------
    typedef struct packed {
        icache_tag_t    tag;
        icache_index_t  index;
        icache_offset_t offset;
        logic [1:0]     byte_sel;    // Always zero on fetch
    } icache_addr_fields_t;

    // Same word, read raw or as fields
    typedef union packed {
        proc_defs_pkg::inst_addr_t raw;
        icache_addr_fields_t       fields;
    } icache_addr_u;

    // -------------------------------------------------------------------
    // Controller states
    // -------------------------------------------------------------------
    typedef enum logic [1:0] {
        CLEAR,        // Invalidate sweep after reset
        LOOKUP,       // Serve CPU, detect miss
        REFILL_REQ,   // Raise memory read for one word
        REFILL_WAIT   // Wait out busy, write on data cycle
    } icache_state_e;

endpackage

/* hw/cache_set.sv */
`include "icache_settings.svh"

module cache_set (
    input  logic                           i_clock,
    input  logic                           i_rst_n,
    input  logic                           i_write,   // Store one refill word
    input  logic                           i_clear,   // Invalidate line at i_index
    input  cache_defs_pkg::icache_tag_t    i_tag,
    input  cache_defs_pkg::icache_index_t  i_index,
    input  cache_defs_pkg::icache_offset_t i_offset,
    input  proc_defs_pkg::inst_t           i_wdata,
    output proc_defs_pkg::inst_t           o_rdata,
    output logic                           o_hit
);
    import proc_defs_pkg::*;
    import cache_defs_pkg::*;

    localparam int LINES = 1 << `ICACHE_INDEX_WIDTH;
    localparam int WORDS = 1 << `ICACHE_OFFSET_WIDTH;

    logic        valid_q [LINES];           // Line holds a complete fill
    icache_tag_t tag_q   [LINES];
    inst_t       data_q  [LINES * WORDS];   // Indexed by {index, offset}

    logic [`ICACHE_INDEX_WIDTH+`ICACHE_OFFSET_WIDTH-1:0] word_sel;

    assign word_sel = {i_index, i_offset};

    // -------------------------------------------------------------------
    // Valid bits
    // -------------------------------------------------------------------
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < LINES; i++)
                valid_q[i] <= 1'b0;
        end else if (i_clear) begin
            valid_q[i_index] <= 1'b0;
        end else if (i_write) begin
            // Line turns invalid on the first word, valid again on the last
            valid_q[i_index] <= (i_offset == '1);
        end
    end

    // -------------------------------------------------------------------
    // Tag and data storage
    // -------------------------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_write) begin
            data_q[word_sel] <= i_wdata;
            if (i_offset == '1)
                tag_q[i_index] <= i_tag;    // Tag lands with last word
        end
    end

    // Combinational read and compare
    assign o_rdata = data_q[word_sel];
    assign o_hit   = valid_q[i_index] && (tag_q[i_index] == i_tag);

    // Controller never sweeps and fills in the same cycle
    a_clear_write_excl: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !(i_clear && i_write));

endmodule

/* hw/fetch_subsystem.sv */
module fetch_subsystem (
    input  logic                      i_clock,
    input  logic                      i_rst_n,

    // CPU fetch port
    input  logic                      i_re,
    input  proc_defs_pkg::inst_addr_t i_addr,
    output proc_defs_pkg::inst_t      o_inst,
    output logic                      o_hit,
    output logic                      o_busy,

    // Memory preload
    input  logic                      i_load_we,
    input  proc_defs_pkg::inst_addr_t i_load_addr,
    input  proc_defs_pkg::inst_t      i_load_data
);
    import proc_defs_pkg::*;

    // Cache to memory link
    inst_addr_t mem_addr;
    logic       mem_re;
    logic       mem_busy;
    inst_t      mem_rdata;

    icache u_icache (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_addr      (i_addr),
        .i_re        (i_re),
        .o_inst      (o_inst),
        .o_busy      (o_busy),
        .o_hit       (o_hit),
        .o_mem_addr  (mem_addr),
        .o_mem_re    (mem_re),
        .i_mem_busy  (mem_busy),
        .i_mem_rdata (mem_rdata)
    );

    inst_memory u_mem (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_re        (mem_re),
        .i_addr      (mem_addr),
        .o_busy      (mem_busy),
        .o_rdata     (mem_rdata),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data)
    );

endmodule

/* hw/icache.sv */
module icache (
    input  logic                       i_clock,
    input  logic                       i_rst_n,

    // CPU side
    input  proc_defs_pkg::inst_addr_t  i_addr,      // Word aligned fetch address
    input  logic                       i_re,
    output proc_defs_pkg::inst_t       o_inst,
    output logic                       o_busy,
    output logic                       o_hit,

    // Memory side
    output proc_defs_pkg::inst_addr_t  o_mem_addr,
    output logic                       o_mem_re,
    input  logic                       i_mem_busy,
    input  proc_defs_pkg::inst_t       i_mem_rdata
);
    import cache_defs_pkg::*;

    icache_addr_u cpu_addr;   // CPU address, split into fields
    icache_addr_u mem_addr;   // Refill address, joined back to raw

    assign cpu_addr.raw = i_addr;

    // -------------------------------------------------------------------
    // Controller
    // -------------------------------------------------------------------
    icache_tag_t    ctrl_tag;
    icache_index_t  ctrl_index;
    icache_offset_t ctrl_offset;
    logic           ctrl_clear;
    logic           ctrl_write;
    logic           ctrl_mem_read;
    logic           ctrl_hit;
    logic           ctrl_busy;
    logic           set_hit;

    icache_controller u_ctrl (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_re          (i_re),
        .i_tag         (cpu_addr.fields.tag),
        .i_index       (cpu_addr.fields.index),
        .i_offset      (cpu_addr.fields.offset),
        .i_hit         (set_hit),
        .i_mem_busy    (i_mem_busy),
        .o_tag         (ctrl_tag),
        .o_index       (ctrl_index),
        .o_offset      (ctrl_offset),
        .o_cache_clear (ctrl_clear),
        .o_cache_write (ctrl_write),
        .o_mem_read    (ctrl_mem_read),
        .o_hit         (ctrl_hit),
        .o_busy        (ctrl_busy)
    );

    // -------------------------------------------------------------------
    // Tag, valid and data arrays
    // -------------------------------------------------------------------
    cache_set u_set (
        .i_clock  (i_clock),
        .i_rst_n  (i_rst_n),
        .i_write  (ctrl_write),
        .i_clear  (ctrl_clear),
        .i_tag    (ctrl_tag),
        .i_index  (ctrl_index),
        .i_offset (ctrl_offset),
        .i_wdata  (i_mem_rdata),   // Memory word written straight in
        .o_rdata  (o_inst),
        .o_hit    (set_hit)
    );

    // Refill word address with zero byte bits
    assign mem_addr.fields = '{tag: ctrl_tag, index: ctrl_index,
                               offset: ctrl_offset, byte_sel: 2'b00};
    assign o_mem_addr = mem_addr.raw;
    assign o_mem_re   = ctrl_mem_read;

    // Nothing reported to an idle CPU
    assign o_hit  = ctrl_hit & i_re;
    assign o_busy = ctrl_busy & i_re;

    // Fetches are word aligned
    a_addr_aligned: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_re |-> (cpu_addr.fields.byte_sel == 2'b00));

endmodule

/* hw/icache_controller.sv */
module icache_controller (
    input  logic                           i_clock,
    input  logic                           i_rst_n,
    input  logic                           i_re,        // CPU read enable
    input  cache_defs_pkg::icache_tag_t    i_tag,       // CPU address fields
    input  cache_defs_pkg::icache_index_t  i_index,
    input  cache_defs_pkg::icache_offset_t i_offset,
    input  logic                           i_hit,       // From cache set
    input  logic                           i_mem_busy,  // From memory
    output cache_defs_pkg::icache_tag_t    o_tag,       // Fields presented to set and memory
    output cache_defs_pkg::icache_index_t  o_index,
    output cache_defs_pkg::icache_offset_t o_offset,
    output logic                           o_cache_clear,
    output logic                           o_cache_write,
    output logic                           o_mem_read,
    output logic                           o_hit,
    output logic                           o_busy
);
    import cache_defs_pkg::*;

    icache_state_e  state_q;
    icache_tag_t    tag_q;     // Refill tag
    icache_index_t  index_q;   // Clear sweep or refill line
    icache_offset_t offset_q;  // Word being refilled

    // -------------------------------------------------------------------
    // State machine
    // -------------------------------------------------------------------
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q  <= CLEAR;
            tag_q    <= '0;
            index_q  <= '0;
            offset_q <= '0;
        end else begin
            case (state_q)
                CLEAR: begin
                    index_q <= index_q + 1'b1;    // One line per cycle
                    if (index_q == '1)
                        state_q <= LOOKUP;
                end
                LOOKUP: begin
                    if (i_re && !i_hit) begin     // Miss, latch line address
                        tag_q    <= i_tag;
                        index_q  <= i_index;
                        offset_q <= '0;           // Fill always starts at word 0
                        state_q  <= REFILL_REQ;
                    end
                end
                REFILL_REQ: state_q <= REFILL_WAIT;
                REFILL_WAIT: begin
                    if (!i_mem_busy) begin        // Data cycle
                        if (offset_q == '1) begin
                            state_q <= LOOKUP;
                        end else begin
                            offset_q <= offset_q + 1'b1;
                            state_q  <= REFILL_REQ;
                        end
                    end
                end
                default: state_q <= CLEAR;
            endcase
        end
    end

    // CPU fields go straight through while looking up
    assign o_tag    = (state_q == LOOKUP) ? i_tag    : tag_q;
    assign o_index  = (state_q == LOOKUP) ? i_index  : index_q;
    assign o_offset = (state_q == LOOKUP) ? i_offset : offset_q;

    assign o_cache_clear = (state_q == CLEAR);
    assign o_cache_write = (state_q == REFILL_WAIT) && !i_mem_busy;
    // Held through busy, dropped on the data cycle so no second fetch starts
    assign o_mem_read    = (state_q == REFILL_REQ) || ((state_q == REFILL_WAIT) && i_mem_busy);
    assign o_hit         = (state_q == LOOKUP) && i_hit;
    assign o_busy        = !o_hit;

    // -------------------------------------------------------------------
    // Checks
    // -------------------------------------------------------------------
    // Memory stays idle and unrequested during the sweep
    a_clear_no_mem: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (state_q == CLEAR) |-> (!o_mem_read && !i_mem_busy));

    // Every word write closes a busy period of the memory
    a_write_after_busy: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_cache_write |-> (state_q == REFILL_WAIT) && !i_mem_busy && $past(i_mem_busy));

endmodule

/* hw/inst_memory.sv */
`include "icache_settings.svh"

module inst_memory (
    input  logic                      i_clock,
    input  logic                      i_rst_n,
    input  logic                      i_re,          // Sampled only when idle
    input  proc_defs_pkg::inst_addr_t i_addr,        // Byte address
    output logic                      o_busy,
    output proc_defs_pkg::inst_t      o_rdata,       // Valid on first not-busy cycle
    input  logic                      i_load_we,     // Preload port
    input  proc_defs_pkg::inst_addr_t i_load_addr,
    input  proc_defs_pkg::inst_t      i_load_data
);
    import proc_defs_pkg::*;

    localparam int MEM_AW = $clog2(`MEM_DEPTH_WORDS);
    localparam int CNT_W  = $clog2(`MEM_LATENCY + 1);

    inst_t             mem [`MEM_DEPTH_WORDS];
    logic [MEM_AW-1:0] addr_q;   // Word address of pending read
    logic [CNT_W-1:0]  cnt_q;    // Busy cycles still to go
    logic              busy_q;
    inst_t             rdata_q;

    // -------------------------------------------------------------------
    // Latency handshake
    // -------------------------------------------------------------------
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (!busy_q && i_re) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(`MEM_LATENCY - 1);
        end else if (busy_q) begin
            if (cnt_q == '0)
                busy_q <= 1'b0;          // Data shows next cycle
            else
                cnt_q <= cnt_q - 1'b1;
        end
    end

    // Array, read address and output word
    always_ff @(posedge i_clock) begin
        if (i_load_we)
            mem[i_load_addr[MEM_AW+1:2]] <= i_load_data;
        if (!busy_q && i_re)
            addr_q <= i_addr[MEM_AW+1:2];
        if (busy_q && (cnt_q == '0))
            rdata_q <= mem[addr_q];
    end

    assign o_busy  = busy_q;
    assign o_rdata = rdata_q;

    // Preload only while no read is pending
    a_load_idle: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_load_we |-> !o_busy);

endmodule

/* hw/proc_defs_pkg.sv */
`include "icache_settings.svh"

// Types seen by the processor side of the fetch path
package proc_defs_pkg;

    // Instruction word as fetched
    typedef logic [31:0] inst_t;

    // Byte address, word aligned when used for fetch
    typedef logic [`INST_ADDR_WIDTH-1:0] inst_addr_t;

endpackage

/* include/icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Cache geometry
`define ICACHE_INDEX_WIDTH   3     // Eight lines
`define ICACHE_OFFSET_WIDTH  2     // Four words per line

// CPU address space
`define INST_ADDR_WIDTH      16    // Byte address bits

// Main memory model
`define MEM_DEPTH_WORDS      1024  // Words in the array
`define MEM_LATENCY          3     // Busy cycles per word read

`endif

/* testbench/fetch_input.txt */
# L byte_addr data : preload one word    R byte_addr : read and check
# X count : random reads over loaded words    I byte_addr : probe with read enable low
I 0040
L 0040 11110000
L 0044 11110004
L 0048 11110008
L 004C 1111000C
L 00C0 22220000
L 00C4 22220004
L 00C8 22220008
L 00CC 2222000C
R 0040
R 0040
R 0044
R 0048
R 004C
R 00C4
R 0040
I 00C0
L 0044 33330004
R 0044
R 00C8
R 0044
X 24
I 0048

/* testbench/tb_fetch_subsystem.sv */
`include "icache_settings.svh"

module tb_fetch_subsystem;
    import proc_defs_pkg::*;

    localparam int AW    = `INST_ADDR_WIDTH;
    localparam int IW    = `ICACHE_INDEX_WIDTH;
    localparam int OW    = `ICACHE_OFFSET_WIDTH;
    localparam int TW    = AW - IW - OW - 2;     // Tag bits above index, offset, byte
    localparam int LINES = 1 << IW;
    localparam int WORDS = 1 << OW;

    logic       clk;
    logic       rst_n;
    logic       i_re;
    inst_addr_t i_addr;
    inst_t      o_inst;
    logic       o_hit;
    logic       o_busy;
    logic       i_load_we;
    inst_addr_t i_load_addr;
    inst_t      i_load_data;

    // Reference state
    logic [31:0]   shadow [int];              // Memory contents by word address
    logic          model_valid [LINES];       // Cache model
    logic [TW-1:0] model_tag   [LINES];
    logic [31:0]   snap [LINES * WORDS];      // Line contents as seen at fill time
    logic [AW-1:0] loaded [$];                // Addresses for random reads

    // Parsed input records
    logic [7:0]    rec_op [$];
    logic [AW-1:0] rec_a  [$];
    logic [31:0]   rec_b  [$];

    string       cur_test;
    int          tests_run;
    int          checks;
    int          errors;
    int          weight;                      // Reads and writes the records add up to
    int          limit_cycles;
    logic [31:0] rng;

    fetch_subsystem dut0 (
        .i_clock     (clk),
        .i_rst_n     (rst_n),
        .i_re        (i_re),
        .i_addr      (i_addr),
        .o_inst      (o_inst),
        .o_hit       (o_hit),
        .o_busy      (o_busy),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data)
    );

    always #10 clk = ~clk;                    // Period 20

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------
    // Input file
    // ------------------------------------------------------------------
    task automatic read_records();
        int            fd;
        int            code;
        logic [63:0]   tok;
        logic [2047:0] skip_buf;
        logic [AW-1:0] a;
        logic [31:0]   b;
        fd = $fopen("testbench/fetch_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/fetch_input.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                a = '0;
                b = '0;
                if (tok == "#") begin
                    code = $fgets(skip_buf, fd);      // Rest of comment line
                end else begin
                    if (tok == "L")
                        code = int'($fscanf(fd, "%h %h", a, b) == 2);
                    else if (tok == "X")
                        code = int'($fscanf(fd, "%d", b) == 1);  // Read count
                    else if (tok == "R" || tok == "I")
                        code = int'($fscanf(fd, "%h", a) == 1);
                    else
                        code = 0;
                    if (code == 0) begin
                        $display("Unknown or incomplete record in input file");
                        errors++;
                    end
                    rec_op.push_back(tok[7:0]);
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                    weight += (tok == "X") ? int'(b) : 1;
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------------
    // Record handlers, all driving on the falling edge
    // ------------------------------------------------------------------
    task automatic load_word(input logic [AW-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        i_re        = 1'b0;                   // Preload only with CPU idle
        i_load_we   = 1'b1;
        i_load_addr = addr;
        i_load_data = data;
        @(negedge clk);
        i_load_we   = 1'b0;
        shadow[int'(addr >> 2)] = data;
        loaded.push_back(addr);
    endtask

    task automatic read_word(input logic [AW-1:0] addr);
        logic [OW-1:0] off;
        logic [IW-1:0] idx;
        logic [TW-1:0] tag;
        int            base;
        logic          exp_hit;
        logic [31:0]   exp_data;
        string         name;
        off  = addr[OW+1:2];
        idx  = addr[IW+OW+1:OW+2];
        tag  = addr[AW-1:IW+OW+2];
        base = int'(addr >> 2) & ~(WORDS - 1);   // First word of the line
        name = $sformatf("%s @%h", cur_test, addr);
        exp_hit = model_valid[idx] && (model_tag[idx] == tag);
        if (!exp_hit) begin                      // Miss refills the whole line from memory
            for (int w = 0; w < WORDS; w++)
                snap[{idx, OW'(w)}] = shadow[base + w];
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
        end
        exp_data = snap[{idx, off}];
        @(negedge clk);
        i_re   = 1'b1;
        i_addr = addr;
        #2;
        compare({name, " first hit"}, 32'(exp_hit), 32'(o_hit));
        compare({name, " first busy"}, 32'(!exp_hit), 32'(o_busy));
        while (o_hit !== 1'b1) begin             // Refill in progress
            @(negedge clk);
            #2;
        end
        compare({name, " data"}, exp_data, o_inst);
    endtask

    task automatic probe_idle(input logic [AW-1:0] addr);
        @(negedge clk);
        i_re   = 1'b0;
        i_addr = addr;
        #2;
        compare({cur_test, " hit"}, 32'd0, 32'(o_hit));
        compare({cur_test, " busy"}, 32'd0, 32'(o_busy));
    endtask

    task automatic random_reads(input logic [31:0] count);
        int pick;
        if (loaded.size() == 0) begin
            $display("Random reads requested before any word was loaded");
            errors++;
        end else begin
            repeat (count) begin
                rng  = xorshift(rng);
                pick = int'(rng % $unsigned(loaded.size()));
                read_word(loaded[pick]);
            end
        end
    endtask

    task automatic report_test(input int errs_before);
        tests_run++;
        if (errors == errs_before)
            $display("[%0d] %s ok", tests_run, cur_test);
        else
            $display("[%0d] %s had %0d mismatches", tests_run, cur_test, errors - errs_before);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin : main
        int errs_before;
        clk         = 1'b0;
        rst_n       = 1'b0;
        i_re        = 1'b0;
        i_addr      = '0;
        i_load_we   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        rng         = 32'd6911;
        model_valid = '{default: 1'b0};
        read_records();
        limit_cycles = weight * 200 + 4 + LINES;

        // CPU idle through reset and the invalidate sweep
        cur_test    = "reset sweep";
        errs_before = errors;
        for (int c = 0; c < 4 + LINES; c++) begin
            @(negedge clk);
            #2;
            compare("reset sweep hit", 32'd0, 32'(o_hit));
            compare("reset sweep busy", 32'd0, 32'(o_busy));
            if (c == 3)
                rst_n = 1'b1;                    // Released after 4 cycles
        end
        report_test(errs_before);

        foreach (rec_op[i]) begin
            errs_before = errors;
            if (rec_op[i] == "X")
                cur_test = $sformatf("X %0d", rec_b[i]);
            else
                cur_test = $sformatf("%c %h", rec_op[i], rec_a[i]);
            case (rec_op[i])
                "L":     load_word(rec_a[i], rec_b[i]);
                "R":     read_word(rec_a[i]);
                "I":     probe_idle(rec_a[i]);
                "X":     random_reads(rec_b[i]);
                default: errors++;
            endcase
            report_test(errs_before);
        end
        @(negedge clk);
        i_re = 1'b0;

        $display("Tests: %0d  checks: %0d  errors: %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // Watchdog sized from the record count once the file is read
    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: test %s did not finish within %0d cycles", cur_test, limit_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
